// ==== sim.f ====
common/fbp_pkg.sv
source/line_ram.sv
fill/fill_controller.sv
source/port_a_arbiter.sv
source/line_accumulator.sv
source/filtered_line_top.sv
verif/tb_filtered_line.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_filtered_line
FILELIST ?= sim.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/tb_filtered_line.sv ====
module tb_filtered_line;
    timeunit 1ns;
    timeprecision 1ps;

    import fbp_pkg::*;

    localparam int line_size = line_size_default;
    localparam int sample_width = sample_width_default;
    localparam int filter_delay = filter_delay_default;
    localparam int sum_width = sample_width + $clog2(line_size) + 1;
    localparam int index_width = $clog2(line_size + 1);
    localparam int addr_width = $clog2(line_size);
    // three fills and fourteen read runs need well under 1500 cycles
    localparam int max_cycles = 4000;

    logic clk;
    logic reset_n;
    logic fill_kick;
    logic signed [sample_width-1:0] host_sample = '0;
    logic [index_width-1:0] host_index;
    logic fill_busy;
    logic fill_done;
    logic rd0_start;
    logic [addr_width-1:0] rd0_base;
    logic [index_width-1:0] rd0_count;
    logic rd0_busy;
    logic rd0_done;
    logic signed [sum_width-1:0] rd0_sum;
    logic rd1_start;
    logic [addr_width-1:0] rd1_base;
    logic [index_width-1:0] rd1_count;
    logic rd1_busy;
    logic rd1_done;
    logic signed [sum_width-1:0] rd1_sum;

    // values the host filter produces for this test
    logic signed [sample_width-1:0] sample_table [line_size];
    logic [index_width-1:0] seen_index = '0;
    // newest index first
    logic [index_width-1:0] index_hist [filter_delay] = '{default: '0};
    int cycle_count;

    filtered_line_top #(
        .line_size(line_size),
        .sample_width(sample_width),
        .filter_delay(filter_delay)
    ) dut0 (
        .clk(clk),
        .reset_n(reset_n),
        .fill_kick(fill_kick),
        .host_sample(host_sample),
        .host_index(host_index),
        .fill_busy(fill_busy),
        .fill_done(fill_done),
        .rd0_start(rd0_start),
        .rd0_base(rd0_base),
        .rd0_count(rd0_count),
        .rd0_busy(rd0_busy),
        .rd0_done(rd0_done),
        .rd0_sum(rd0_sum),
        .rd1_start(rd1_start),
        .rd1_base(rd1_base),
        .rd1_count(rd1_count),
        .rd1_busy(rd1_busy),
        .rd1_done(rd1_done),
        .rd1_sum(rd1_sum)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic signed [sample_width-1:0] table_value(logic [index_width-1:0] idx);
        if (idx < index_width'(line_size))
            return sample_table[idx[addr_width-1:0]];
        else
            return '0;
    endfunction

    // host filter model, a delay line on the index
    always @(negedge clk)
        seen_index = host_index;

    always @(posedge clk)
    begin
        for (int j = filter_delay - 1; j > 0; j--)
            index_hist[j] = index_hist[j - 1];
        index_hist[0] = seen_index;
        host_sample <= table_value(index_hist[filter_delay - 1]);
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < max_cycles)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the tests did not finish within %0d cycles", max_cycles);
        $display("** FAIL **");
        $fatal(1, "run stopped by the cycle limit");
    end

    task automatic check_equal(string test_name, string what, longint expected, longint actual);
        if (expected != actual)
        begin
            $display("error: %s %s expected %0d actual %0d", test_name, what, expected, actual);
            $display("** FAIL **");
            $fatal(1, "%s: wrong %s", test_name, what);
        end
    endtask

    function automatic longint table_sum(int base, int count);
        longint total;
        total = 0;
        for (int i = base; i < base + count; i++)
            total += longint'(sample_table[i]);
        return total;
    endfunction

    task automatic random_table();
        for (int i = 0; i < line_size; i++)
            sample_table[i] = sample_width'($urandom());
    endtask

    // returns cycles from the kick cycle to the fill_done cycle
    task automatic kick_fill(output int cycles);
        @(posedge clk);
        fill_kick <= 1'b1;
        @(posedge clk);
        fill_kick <= 1'b0;
        cycles = 1;
        @(negedge clk);
        while (!fill_done)
        begin
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic launch_reads(bit go0, int base0, int count0, bit go1, int base1, int count1);
        @(posedge clk);
        rd0_start <= go0;
        rd0_base <= addr_width'(base0);
        rd0_count <= index_width'(count0);
        rd1_start <= go1;
        rd1_base <= addr_width'(base1);
        rd1_count <= index_width'(count1);
        @(posedge clk);
        rd0_start <= 1'b0;
        rd1_start <= 1'b0;
    endtask

    task automatic wait_reads(bit go0, bit go1, output longint sum0, output longint sum1);
        bit got0;
        bit got1;
        got0 = !go0;
        got1 = !go1;
        sum0 = 0;
        sum1 = 0;
        while (!(got0 && got1))
        begin
            @(negedge clk);
            if (rd0_done && !got0)
            begin
                got0 = 1'b1;
                sum0 = longint'(rd0_sum);
            end
            if (rd1_done && !got1)
            begin
                got1 = 1'b1;
                sum1 = longint'(rd1_sum);
            end
        end
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check_equal("reset_state", "fill_busy", 0, longint'(fill_busy));
        check_equal("reset_state", "fill_done", 0, longint'(fill_done));
        check_equal("reset_state", "rd0_done", 0, longint'(rd0_done));
        check_equal("reset_state", "rd1_done", 0, longint'(rd1_done));
        check_equal("reset_state", "rd0_busy", 0, longint'(rd0_busy));
        check_equal("reset_state", "rd1_busy", 0, longint'(rd1_busy));
    endtask

    task automatic test_fill_timing();
        int cycles;
        // ramp, reused by the next test
        for (int i = 0; i < line_size; i++)
            sample_table[i] = sample_width'(10 * i + 5);
        kick_fill(cycles);
        check_equal("fill_timing", "kick to fill_done cycles",
                    longint'(filter_delay + line_size), longint'(cycles));
        check_equal("fill_timing", "fill_busy at done", 1, longint'(fill_busy));
        // read index saturates at the line end
        check_equal("fill_timing", "host_index at done", longint'(line_size),
                    longint'(host_index));
        @(negedge clk);
        check_equal("fill_timing", "fill_busy after done", 0, longint'(fill_busy));
    endtask

    task automatic test_ramp_sums();
        int base;
        int count;
        longint sum0;
        longint sum1;
        launch_reads(1'b0, 0, 0, 1'b1, 0, line_size);
        wait_reads(1'b0, 1'b1, sum0, sum1);
        check_equal("ramp_sums", "rd1 sum of full line", table_sum(0, line_size), sum1);
        check_equal("ramp_sums", "rd1_busy at done", 0, longint'(rd1_busy));
        repeat (8)
        begin
            base = $urandom % line_size;
            count = 1 + $urandom % (line_size - base);
            launch_reads(1'b0, 0, 0, 1'b1, base, count);
            wait_reads(1'b0, 1'b1, sum0, sum1);
            check_equal("ramp_sums", "rd1 sum", table_sum(base, count), sum1);
        end
    endtask

    task automatic test_signed_sums();
        int cycles;
        int base0;
        int count0;
        int base1;
        int count1;
        longint sum0;
        longint sum1;
        random_table();
        kick_fill(cycles);
        check_equal("signed_sums", "kick to fill_done cycles",
                    longint'(filter_delay + line_size), longint'(cycles));
        // both readers at once, port a and port b
        repeat (4)
        begin
            base0 = $urandom % line_size;
            count0 = 1 + $urandom % (line_size - base0);
            base1 = $urandom % line_size;
            count1 = 1 + $urandom % (line_size - base1);
            launch_reads(1'b1, base0, count0, 1'b1, base1, count1);
            wait_reads(1'b1, 1'b1, sum0, sum1);
            check_equal("signed_sums", "rd0 sum", table_sum(base0, count0), sum0);
            check_equal("signed_sums", "rd1 sum", table_sum(base1, count1), sum1);
        end
    endtask

    task automatic test_back_pressure();
        int base;
        int count;
        bit fill_seen;
        random_table();
        base = $urandom % line_size;
        count = 1 + $urandom % (line_size - base);
        @(posedge clk);
        fill_kick <= 1'b1;
        @(posedge clk);
        fill_kick <= 1'b0;
        // start reader 0 once the fill holds port a
        repeat (filter_delay) @(posedge clk);
        launch_reads(1'b1, base, count, 1'b0, 0, 0);
        fill_seen = 1'b0;
        @(negedge clk);
        while (!rd0_done)
        begin
            if (fill_done)
            begin
                fill_seen = 1'b1;
                // stalled reader still owns its run
                check_equal("back_pressure", "rd0_busy at fill_done", 1, longint'(rd0_busy));
            end
            @(negedge clk);
        end
        check_equal("back_pressure", "fill_done before rd0_done", 1, longint'(fill_seen));
        check_equal("back_pressure", "rd0_busy at done", 0, longint'(rd0_busy));
        check_equal("back_pressure", "rd0 sum", table_sum(base, count), longint'(rd0_sum));
    endtask

    initial
    begin
        void'($urandom(8));
        reset_n = 1'b0;
        fill_kick = 1'b0;
        rd0_start = 1'b0;
        rd0_base = '0;
        rd0_count = '0;
        rd1_start = 1'b0;
        rd1_base = '0;
        rd1_count = '0;
        for (int i = 0; i < line_size; i++)
            sample_table[i] = '0;
        repeat (4) @(posedge clk);
        reset_n <= 1'b1;
        test_reset_state();
        test_fill_timing();
        test_ramp_sums();
        test_signed_sums();
        test_back_pressure();
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== source/filtered_line_top.sv ====
module filtered_line_top
#(
    parameter int line_size = fbp_pkg::line_size_default,
    parameter int sample_width = fbp_pkg::sample_width_default,
    parameter int filter_delay = fbp_pkg::filter_delay_default,
    localparam int sum_width = sample_width + $clog2(line_size) + 1
)
(
    input logic clk,
    input logic reset_n,
    input logic fill_kick,
    input logic signed [sample_width-1:0] host_sample,
    output logic [$clog2(line_size + 1)-1:0] host_index,
    output logic fill_busy,
    output logic fill_done,
    input logic rd0_start,
    input logic [$clog2(line_size)-1:0] rd0_base,
    input logic [$clog2(line_size + 1)-1:0] rd0_count,
    output logic rd0_busy,
    output logic rd0_done,
    output logic signed [sum_width-1:0] rd0_sum,
    input logic rd1_start,
    input logic [$clog2(line_size)-1:0] rd1_base,
    input logic [$clog2(line_size + 1)-1:0] rd1_count,
    output logic rd1_busy,
    output logic rd1_done,
    output logic signed [sum_width-1:0] rd1_sum
);

    import fbp_pkg::*;

    ram_req_t fill_req;
    ram_req_t rd0_req;
    ram_req_t rd1_req;
    ram_req_t port_a_req;
    rd_rsp_t rd0_rsp;
    rd_rsp_t rd1_rsp;
    logic rd0_grant;
    logic rd1_read_q;
    logic signed [sample_width-1:0] port_a_data;
    logic signed [sample_width-1:0] port_b_data;

    fill_controller #(
        .line_size(line_size),
        .filter_delay(filter_delay),
        .sample_width(sample_width)
    ) fill0 (
        .clk(clk),
        .reset_n(reset_n),
        .fill_kick(fill_kick),
        .host_sample(host_sample),
        .host_index(host_index),
        .fill_busy(fill_busy),
        .fill_done(fill_done),
        .fill_req(fill_req)
    );

    port_a_arbiter #(
        .sample_width(sample_width)
    ) arb0 (
        .clk(clk),
        .reset_n(reset_n),
        .fill_req(fill_req),
        .rd0_req(rd0_req),
        .port_a_data(port_a_data),
        .rd0_grant(rd0_grant),
        .port_a_req(port_a_req),
        .rd0_rsp(rd0_rsp)
    );

    line_ram #(
        .line_size(line_size),
        .sample_width(sample_width)
    ) ram0 (
        .clk(clk),
        .port_a_req(port_a_req),
        .port_b_req(rd1_req),
        .port_a_data(port_a_data),
        .port_b_data(port_b_data)
    );

    // port b belongs to reader 1 alone
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            rd1_read_q <= 1'b0;
        else
            rd1_read_q <= rd1_req.valid;
    end

    always_comb
    begin
        rd1_rsp.valid = rd1_read_q;
        rd1_rsp.data = sample_width_default'(port_b_data);
    end

    line_accumulator #(
        .line_size(line_size),
        .sample_width(sample_width),
        .sum_width(sum_width)
    ) rd0 (
        .clk(clk),
        .reset_n(reset_n),
        .start(rd0_start),
        .base(rd0_base),
        .count(rd0_count),
        .grant(rd0_grant),
        .rsp(rd0_rsp),
        .req(rd0_req),
        .busy(rd0_busy),
        .done(rd0_done),
        .sum(rd0_sum)
    );

    line_accumulator #(
        .line_size(line_size),
        .sample_width(sample_width),
        .sum_width(sum_width)
    ) rd1 (
        .clk(clk),
        .reset_n(reset_n),
        .start(rd1_start),
        .base(rd1_base),
        .count(rd1_count),
        .grant(1'b1),
        .rsp(rd1_rsp),
        .req(rd1_req),
        .busy(rd1_busy),
        .done(rd1_done),
        .sum(rd1_sum)
    );

endmodule

// ==== source/line_accumulator.sv ====
module line_accumulator
#(
    parameter int line_size = fbp_pkg::line_size_default,
    parameter int sample_width = fbp_pkg::sample_width_default,
    parameter int sum_width = sample_width + $clog2(line_size) + 1
)
(
    input logic clk,
    input logic reset_n,
    input logic start,
    input logic [$clog2(line_size)-1:0] base,
    input logic [$clog2(line_size + 1)-1:0] count,
    input logic grant,
    input fbp_pkg::rd_rsp_t rsp,
    output fbp_pkg::ram_req_t req,
    output logic busy,
    output logic done,
    output logic signed [sum_width-1:0] sum
);

    import fbp_pkg::*;

    localparam int addr_width = $clog2(line_size);
    localparam int count_width = $clog2(line_size + 1);

    logic [addr_width-1:0] issue_addr;
    logic [count_width-1:0] issue_left;
    logic [count_width-1:0] return_left;
    logic [count_width-1:0] in_flight;
    logic issue;

    // reads sent but not yet returned
    assign in_flight = return_left - issue_left;
    assign issue = req.valid && grant;

    always_comb
    begin
        req.valid = busy && (issue_left != '0) && (in_flight < count_width'(2));
        req.write = 1'b0;
        req.addr = addr_width_default'(issue_addr);
        req.wdata = '0;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            busy <= 1'b0;
            done <= 1'b0;
            issue_addr <= '0;
            issue_left <= '0;
            return_left <= '0;
        end
        else
        begin
            done <= 1'b0;
            if (start && !busy)
            begin
                issue_addr <= base;
                issue_left <= count;
                return_left <= count;
                busy <= (count != '0);
                // empty run finishes at once
                done <= (count == '0);
            end
            else if (busy)
            begin
                // no grant means hold the address
                if (issue)
                begin
                    issue_addr <= issue_addr + 1'b1;
                    issue_left <= issue_left - 1'b1;
                end
                if (rsp.valid)
                begin
                    return_left <= return_left - 1'b1;
                    if (return_left == count_width'(1))
                    begin
                        busy <= 1'b0;
                        done <= 1'b1;
                    end
                end
            end
        end
    end

    // running sum, sign extended samples
    always_ff @(posedge clk)
    begin
        if (start && !busy)
            sum <= '0;
        else if (busy && rsp.valid)
            sum <= sum + sum_width'($signed(rsp.data[sample_width-1:0]));
    end

endmodule

// ==== source/port_a_arbiter.sv ====
module port_a_arbiter
#(
    parameter int sample_width = fbp_pkg::sample_width_default
)
(
    input logic clk,
    input logic reset_n,
    input fbp_pkg::ram_req_t fill_req,
    input fbp_pkg::ram_req_t rd0_req,
    input logic signed [sample_width-1:0] port_a_data,
    output logic rd0_grant,
    output fbp_pkg::ram_req_t port_a_req,
    output fbp_pkg::rd_rsp_t rd0_rsp
);

    import fbp_pkg::*;

    logic rd0_read_q;

    // fill always wins
    assign rd0_grant = !fill_req.valid;

    always_comb
    begin
        if (fill_req.valid)
            port_a_req = fill_req;
        else
            port_a_req = rd0_req;
    end

    // remember who owned last cycle's read
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            rd0_read_q <= 1'b0;
        else
            rd0_read_q <= rd0_grant && rd0_req.valid && !rd0_req.write;
    end

    always_comb
    begin
        rd0_rsp.valid = rd0_read_q;
        rd0_rsp.data = sample_width_default'(port_a_data);
    end

endmodule

// ==== fill/fill_controller.sv ====
module fill_controller
#(
    parameter int line_size = fbp_pkg::line_size_default,
    parameter int filter_delay = fbp_pkg::filter_delay_default,
    parameter int sample_width = fbp_pkg::sample_width_default
)
(
    input logic clk,
    input logic reset_n,
    input logic fill_kick,
    input logic signed [sample_width-1:0] host_sample,
    output logic [$clog2(line_size + 1)-1:0] host_index,
    output logic fill_busy,
    output logic fill_done,
    output fbp_pkg::ram_req_t fill_req
);

    import fbp_pkg::*;

    localparam int index_width = $clog2(line_size + 1);
    localparam int addr_width = $clog2(line_size);

    fill_state_e state;
    fill_state_e next_state;
    logic [index_width-1:0] read_itr;
    logic [addr_width-1:0] write_itr;
    logic delay_done;
    logic last_write;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            state <= state_ready;
        else
            state <= next_state;
    end

    // read side runs filter_delay ahead of the write side
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            read_itr <= '0;
            write_itr <= '0;
        end
        else if (state == state_ready)
        begin
            read_itr <= '0;
            write_itr <= '0;
        end
        else if (state == state_delay)
        begin
            read_itr <= read_itr + 1'b1;
        end
        else if (state == state_fill)
        begin
            write_itr <= write_itr + 1'b1;
            // stop at the end of the line
            if (read_itr != index_width'(line_size))
                read_itr <= read_itr + 1'b1;
        end
    end

    assign delay_done = (read_itr == index_width'(filter_delay - 1));
    assign last_write = (write_itr == addr_width'(line_size - 1));

    always_comb
    begin
        next_state = state;
        case (state)
            state_ready:
                if (fill_kick)
                    next_state = state_delay;
            state_delay:
                if (delay_done)
                    next_state = state_fill;
            state_fill:
                if (last_write)
                    next_state = state_ready;
            default:
                next_state = state_ready;
        endcase
    end

    // mealy outputs
    assign host_index = read_itr;
    assign fill_busy = (state != state_ready);
    assign fill_done = (state == state_fill) && last_write;

    always_comb
    begin
        fill_req.valid = (state == state_fill);
        fill_req.write = (state == state_fill);
        fill_req.addr = addr_width_default'(write_itr);
        // sample arriving now belongs to write_itr
        fill_req.wdata = sample_width_default'(host_sample);
    end

endmodule

// ==== source/line_ram.sv ====
module line_ram
#(
    parameter int line_size = fbp_pkg::line_size_default,
    parameter int sample_width = fbp_pkg::sample_width_default
)
(
    input logic clk,
    input fbp_pkg::ram_req_t port_a_req,
    input fbp_pkg::ram_req_t port_b_req,
    output logic signed [sample_width-1:0] port_a_data,
    output logic signed [sample_width-1:0] port_b_data
);

    localparam int addr_width = $clog2(line_size);

    logic signed [sample_width-1:0] mem [line_size];

    // port a, shared by fill and reader 0
    always_ff @(posedge clk)
    begin
        if (port_a_req.valid)
        begin
            if (port_a_req.write)
                mem[port_a_req.addr[addr_width-1:0]] <= port_a_req.wdata[sample_width-1:0];
            else
                port_a_data <= mem[port_a_req.addr[addr_width-1:0]];
        end
    end

    // port b is read only
    always_ff @(posedge clk)
    begin
        if (port_b_req.valid)
            port_b_data <= mem[port_b_req.addr[addr_width-1:0]];
    end

endmodule

// ==== common/fbp_pkg.sv ====
package fbp_pkg;

    // default line geometry and sample format
    localparam int sample_width_default = 16;
    localparam int line_size_default = 64;
    // half the filter order
    localparam int filter_delay_default = 4;
    localparam int addr_width_default = $clog2(line_size_default);

    // fill sequencer states
    typedef enum logic [1:0]
    {
        state_ready = 2'd0,
        state_delay = 2'd1,
        state_fill = 2'd2
    } fill_state_e;

    // one access on a RAM port
    typedef struct packed
    {
        logic valid;
        logic write;
        logic [addr_width_default-1:0] addr;
        logic signed [sample_width_default-1:0] wdata;
    } ram_req_t;

    // read data handed back to a reader
    typedef struct packed
    {
        logic valid;
        logic signed [sample_width_default-1:0] data;
    } rd_rsp_t;

endpackage
